// ==== cache_pkg.sv ====
`default_nettype none

package cache_pkg;

	// address and data geometry
	// --------------------
	localparam int BW_WORD_ADDR = 24;                    // word address width
	localparam int BW_BLOCK     = 2;                     // word offset bits, 4 words per block
	localparam int BW_TAG       = BW_WORD_ADDR - BW_BLOCK;
	localparam int BW_DATA      = 32;

	// one word address, seen flat or split
	typedef union packed {
		logic [BW_WORD_ADDR-1:0] flat;                   // as sent to memory
		struct packed {
			logic [BW_TAG-1:0]   tag;                    // block number
			logic [BW_BLOCK-1:0] word;                   // word within block
		} field;
	} word_addr_u;

endpackage

`default_nettype wire

// ==== fill_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

module fill_counters
	import cache_pkg::*;
#(
	parameter int CACHE_BLOCK_CAPACITY = 8,
	localparam int BW_LINE = $clog2(CACHE_BLOCK_CAPACITY)
) (
	input  wire logic               clock_i,
	input  wire logic               resetn_i,
	input  wire logic               word_step_i,     // one word moved this cycle
	input  wire logic               victim_step_i,   // line filled, advance pointer
	output logic [BW_BLOCK-1:0]     word_o,
	output logic                    last_word_o,
	output logic [BW_LINE-1:0]      victim_o
);

	localparam logic [BW_LINE-1:0] LAST_LINE = BW_LINE'(CACHE_BLOCK_CAPACITY - 1);

	assign last_word_o = &word_o;                    // final word of the block

	// --------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			word_o   <= '0;
			victim_o <= '0;                          // first victim is line 0
		end else begin
			if (word_step_i) begin
				word_o <= word_o + 1'b1;             // wraps to 0 after last word
			end
			// round robin over all lines
			if (victim_step_i) begin
				if (victim_o == LAST_LINE) begin
					victim_o <= '0;
				end else begin
					victim_o <= victim_o + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== tag_cam.sv ====
`timescale 1ns/1ps
`default_nettype none

module tag_cam
	import cache_pkg::*;
#(
	parameter int CACHE_BLOCK_CAPACITY = 8,
	localparam int BW_LINE = $clog2(CACHE_BLOCK_CAPACITY)
) (
	input  wire logic               clock_i,
	input  wire logic               resetn_i,
	input  wire word_addr_u         lookup_addr_i,       // core address under search
	input  wire logic               write_i,             // install lookup tag at victim
	input  wire logic               set_dirty_i,
	input  wire logic [BW_LINE-1:0] set_dirty_index_i,
	input  wire logic [BW_LINE-1:0] victim_i,
	output logic                    hit_o,
	output logic      [BW_LINE-1:0] hit_index_o,
	output logic      [BW_TAG-1:0]  victim_tag_o,        // for writeback address
	output logic                    victim_dirty_o
);

	logic [BW_TAG-1:0]               tag_q [CACHE_BLOCK_CAPACITY];
	logic [CACHE_BLOCK_CAPACITY-1:0] valid_q;
	logic [CACHE_BLOCK_CAPACITY-1:0] dirty_q;

	// status bits
	// --------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else begin
			if (set_dirty_i) begin
				dirty_q[set_dirty_index_i] <= 1'b1;      // store hit
			end
			if (write_i) begin
				valid_q[victim_i] <= 1'b1;
				dirty_q[victim_i] <= 1'b0;               // fresh block is clean
			end
		end
	end

	// tag words, only meaningful under valid
	always_ff @(posedge clock_i) begin
		if (write_i) begin
			tag_q[victim_i] <= lookup_addr_i.field.tag;
		end
	end

	// parallel search
	// --------------------
	always_comb begin
		hit_o       = 1'b0;
		hit_index_o = '0;
		for (int i = 0; i < CACHE_BLOCK_CAPACITY; i++) begin
			if (valid_q[i] && (tag_q[i] == lookup_addr_i.field.tag)) begin
				hit_o       = 1'b1;
				hit_index_o = BW_LINE'(i);           // tags are unique, at most one match
			end
		end
	end

	// victim readout
	assign victim_tag_o   = tag_q[victim_i];
	assign victim_dirty_o = dirty_q[victim_i];       // only ever set on a valid line

endmodule

`default_nettype wire

// ==== line_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_store
	import cache_pkg::*;
#(
	parameter int CACHE_BLOCK_CAPACITY = 8,
	localparam int BW_LINE = $clog2(CACHE_BLOCK_CAPACITY)
) (
	input  wire logic                        clock_i,
	input  wire logic                        wr_i,
	input  wire logic [BW_LINE+BW_BLOCK-1:0] addr_i,   // {line, word}
	input  wire logic [BW_DATA-1:0]          data_i,
	output logic      [BW_DATA-1:0]          data_o
);

	localparam int DEPTH = CACHE_BLOCK_CAPACITY << BW_BLOCK;

	logic [BW_DATA-1:0] mem_q [DEPTH];                 // all cached words

	// write port
	// --------------------
	always_ff @(posedge clock_i) begin
		if (wr_i) begin
			mem_q[addr_i] <= data_i;
		end
	end

	// async read, address comes in registered from the fsm
	assign data_o = mem_q[addr_i];

endmodule

`default_nettype wire

// ==== cache_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_fsm
	import cache_pkg::*;
#(
	parameter int CACHE_BLOCK_CAPACITY = 8,
	localparam int BW_LINE = $clog2(CACHE_BLOCK_CAPACITY)
) (
	input  wire logic                        clock_i,
	input  wire logic                        resetn_i,
	input  wire logic                        enable_i,
	// core
	input  wire logic                        core_req_i,
	input  wire logic                        core_rw_i,
	input  wire word_addr_u                  core_addr_i,
	input  wire logic [BW_DATA-1:0]          core_data_i,
	// tag store
	input  wire logic                        cam_hit_i,
	input  wire logic [BW_LINE-1:0]          cam_index_i,
	input  wire logic [BW_TAG-1:0]           victim_tag_i,
	input  wire logic                        victim_dirty_i,
	// counters
	input  wire logic [BW_BLOCK-1:0]         word_i,
	input  wire logic                        last_word_i,
	input  wire logic [BW_LINE-1:0]          victim_i,
	input  wire logic [BW_DATA-1:0]          rd_data_i,      // line store read data
	// buffers and memory
	input  wire logic                        buffer_read_ready_i,
	input  wire logic [BW_DATA-1:0]          buffer_data_i,
	input  wire logic                        buffer_write_ready_i,
	input  wire logic                        mem_ready_i,
	output logic                             word_step_o,
	output logic                             victim_step_o,
	output logic                             cam_write_o,
	output logic                             set_dirty_o,
	output logic      [BW_LINE-1:0]          set_dirty_index_o,
	output logic                             wr_o,
	output logic      [BW_LINE+BW_BLOCK-1:0] addr_o,
	output logic      [BW_DATA-1:0]          wr_data_o,
	output logic                             core_done_o,
	output logic                             core_hit_o,
	output logic      [BW_DATA-1:0]          core_data_o,
	output logic                             buffer_read_ack_o,
	output logic      [BW_DATA-1:0]          buffer_data_o,
	output logic                             buffer_write_ack_o,
	output logic                             mem_req_o,
	output logic                             mem_rw_o,
	output word_addr_u                       mem_addr_o,
	output logic                             flag_hit_o,
	output logic                             flag_miss_o,
	output logic                             flag_writeback_o
);

	localparam logic [2:0] ST_NORMAL       = 3'd0;   // hit/miss check
	localparam logic [2:0] ST_WAIT_READY   = 3'd1;   // block read request
	localparam logic [2:0] ST_PICK_VICTIM  = 3'd2;   // dirty check on victim
	localparam logic [2:0] ST_WRITE_BUFFER = 3'd3;   // victim -> write buffer
	localparam logic [2:0] ST_READ_BUFFER  = 3'd4;   // read buffer -> victim

	logic [2:0]          state_q;
	logic                req_pending_q;              // stalled core request awaits replay
	logic                wb_pending_q;               // write request still owed
	word_addr_u          wb_addr_q;
	logic                serve;
	logic                push;
	logic                pop;
	logic [BW_BLOCK-1:0] next_word;

	// a held request is not served twice while done is up
	assign serve     = (core_req_i & ~core_done_o) | req_pending_q;
	assign push      = enable_i & (state_q == ST_WRITE_BUFFER) & buffer_write_ready_i;
	assign pop       = enable_i & (state_q == ST_READ_BUFFER) & buffer_read_ready_i;
	assign next_word = word_i + 1'b1;

	// buffer side and counter strobes
	// --------------------
	assign buffer_write_ack_o = push;
	assign buffer_read_ack_o  = pop;
	assign buffer_data_o      = rd_data_i;           // word at the registered line address
	assign word_step_o        = push | pop;
	assign victim_step_o      = pop & last_word_i;   // line filled
	assign cam_write_o        = pop & last_word_i;   // same edge, still the old victim

	assign core_hit_o  = (core_req_i | req_pending_q) ? cam_hit_i : 1'b1;
	assign core_data_o = rd_data_i;

	// sequencing
	// --------------------
	always_ff @(posedge clock_i) begin
		core_done_o      <= 1'b0;                    // pulses
		mem_req_o        <= 1'b0;
		flag_hit_o       <= 1'b0;
		flag_miss_o      <= 1'b0;
		flag_writeback_o <= 1'b0;
		wr_o             <= 1'b0;
		set_dirty_o      <= 1'b0;
		if (!resetn_i) begin
			state_q       <= ST_NORMAL;
			req_pending_q <= 1'b0;
			wb_pending_q  <= 1'b0;
			mem_rw_o      <= 1'b0;
		end else if (enable_i) begin             // frozen otherwise
			case (state_q)
				ST_NORMAL: begin
					if (serve) begin
						if (cam_hit_i) begin
							// new hit or replay after fill
							flag_hit_o        <= 1'b1;
							core_done_o       <= 1'b1;
							req_pending_q     <= 1'b0;
							addr_o            <= {cam_index_i, core_addr_i.field.word};
							wr_o              <= core_rw_i;
							wr_data_o         <= core_data_i;
							set_dirty_o       <= core_rw_i;
							set_dirty_index_o <= cam_index_i;
						end else begin
							flag_miss_o   <= 1'b1;
							req_pending_q <= 1'b1;   // core keeps its inputs steady
							state_q       <= ST_WAIT_READY;
						end
					end
				end
				ST_WAIT_READY: begin
					// no read while a writeback is still unsent
					if (mem_ready_i && !wb_pending_q) begin
						mem_req_o              <= 1'b1;
						mem_rw_o               <= 1'b0;
						mem_addr_o.field.tag   <= core_addr_i.field.tag;
						mem_addr_o.field.word  <= '0;
						state_q                <= ST_PICK_VICTIM;
					end
				end
				ST_PICK_VICTIM: begin
					if (victim_dirty_i) begin
						flag_writeback_o <= 1'b1;
						addr_o           <= {victim_i, {BW_BLOCK{1'b0}}};   // word 0 first
						state_q          <= ST_WRITE_BUFFER;
					end else begin
						state_q <= ST_READ_BUFFER;
					end
				end
				ST_WRITE_BUFFER: begin
					if (push) begin
						addr_o <= {victim_i, next_word};    // prefetch next word
						if (word_i == '0) begin
							wb_pending_q          <= 1'b1;
							wb_addr_q.field.tag   <= victim_tag_i;
							wb_addr_q.field.word  <= '0;
						end
						if (last_word_i) begin
							state_q <= ST_READ_BUFFER;
						end
					end
				end
				ST_READ_BUFFER: begin
					if (pop) begin
						wr_o      <= 1'b1;
						addr_o    <= {victim_i, word_i};
						wr_data_o <= buffer_data_i;
						if (last_word_i) begin
							state_q <= ST_NORMAL;    // replay next
						end
					end
				end
				default: state_q <= ST_NORMAL;
			endcase

			// deferred block write, wins over any other request
			if (wb_pending_q && mem_ready_i) begin
				wb_pending_q <= 1'b0;
				mem_req_o    <= 1'b1;
				mem_rw_o     <= 1'b1;
				mem_addr_o   <= wb_addr_q;
			end
		end
	end

endmodule

`default_nettype wire

// ==== fa_cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fa_cache_top
	import cache_pkg::*;
#(
	parameter int CACHE_BLOCK_CAPACITY = 8
) (
	input  wire logic               clock_i,
	input  wire logic               resetn_i,
	input  wire logic               enable_i,
	// core
	input  wire logic               core_req_i,
	input  wire logic               core_rw_i,
	input  wire word_addr_u         core_addr_i,
	input  wire logic [BW_DATA-1:0] core_data_i,
	output logic                    core_done_o,
	output logic                    core_hit_o,
	output logic      [BW_DATA-1:0] core_data_o,
	// word buffers
	input  wire logic               buffer_read_ready_i,
	input  wire logic [BW_DATA-1:0] buffer_data_i,
	output logic                    buffer_read_ack_o,
	input  wire logic               buffer_write_ready_i,
	output logic      [BW_DATA-1:0] buffer_data_o,
	output logic                    buffer_write_ack_o,
	// memory commands
	input  wire logic               mem_ready_i,
	output logic                    mem_req_o,
	output logic                    mem_rw_o,
	output word_addr_u              mem_addr_o,
	// perf pulses
	output logic                    flag_hit_o,
	output logic                    flag_miss_o,
	output logic                    flag_writeback_o
);

	localparam int BW_LINE = $clog2(CACHE_BLOCK_CAPACITY);

	logic                        word_step;
	logic                        victim_step;
	logic                        cam_write;
	logic                        set_dirty;
	logic [BW_LINE-1:0]          set_dirty_index;
	logic                        wr;
	logic [BW_LINE+BW_BLOCK-1:0] addr;
	logic [BW_DATA-1:0]          wr_data;
	logic [BW_DATA-1:0]          rd_data;
	logic                        cam_hit;
	logic [BW_LINE-1:0]          cam_index;
	logic [BW_TAG-1:0]           victim_tag;
	logic                        victim_dirty;
	logic [BW_BLOCK-1:0]         word;
	logic                        last_word;
	logic [BW_LINE-1:0]          victim;

	// controller
	// --------------------
	cache_fsm #(
		.CACHE_BLOCK_CAPACITY (CACHE_BLOCK_CAPACITY)
	) i_cache_fsm (
		.clock_i              (clock_i),
		.resetn_i             (resetn_i),
		.enable_i             (enable_i),
		.core_req_i           (core_req_i),
		.core_rw_i            (core_rw_i),
		.core_addr_i          (core_addr_i),
		.core_data_i          (core_data_i),
		.cam_hit_i            (cam_hit),
		.cam_index_i          (cam_index),
		.victim_tag_i         (victim_tag),
		.victim_dirty_i       (victim_dirty),
		.word_i               (word),
		.last_word_i          (last_word),
		.victim_i             (victim),
		.rd_data_i            (rd_data),
		.buffer_read_ready_i  (buffer_read_ready_i),
		.buffer_data_i        (buffer_data_i),
		.buffer_write_ready_i (buffer_write_ready_i),
		.mem_ready_i          (mem_ready_i),
		.word_step_o          (word_step),
		.victim_step_o        (victim_step),
		.cam_write_o          (cam_write),
		.set_dirty_o          (set_dirty),
		.set_dirty_index_o    (set_dirty_index),
		.wr_o                 (wr),
		.addr_o               (addr),
		.wr_data_o            (wr_data),
		.core_done_o          (core_done_o),
		.core_hit_o           (core_hit_o),
		.core_data_o          (core_data_o),
		.buffer_read_ack_o    (buffer_read_ack_o),
		.buffer_data_o        (buffer_data_o),
		.buffer_write_ack_o   (buffer_write_ack_o),
		.mem_req_o            (mem_req_o),
		.mem_rw_o             (mem_rw_o),
		.mem_addr_o           (mem_addr_o),
		.flag_hit_o           (flag_hit_o),
		.flag_miss_o          (flag_miss_o),
		.flag_writeback_o     (flag_writeback_o)
	);

	fill_counters #(
		.CACHE_BLOCK_CAPACITY (CACHE_BLOCK_CAPACITY)
	) i_fill_counters (
		.clock_i       (clock_i),
		.resetn_i      (resetn_i),
		.word_step_i   (word_step),
		.victim_step_i (victim_step),
		.word_o        (word),
		.last_word_o   (last_word),
		.victim_o      (victim)
	);

	// storage
	// --------------------
	tag_cam #(
		.CACHE_BLOCK_CAPACITY (CACHE_BLOCK_CAPACITY)
	) i_tag_cam (
		.clock_i           (clock_i),
		.resetn_i          (resetn_i),
		.lookup_addr_i     (core_addr_i),
		.write_i           (cam_write),
		.set_dirty_i       (set_dirty),
		.set_dirty_index_i (set_dirty_index),
		.victim_i          (victim),        // shared with the fsm
		.hit_o             (cam_hit),
		.hit_index_o       (cam_index),
		.victim_tag_o      (victim_tag),
		.victim_dirty_o    (victim_dirty)
	);

	line_store #(
		.CACHE_BLOCK_CAPACITY (CACHE_BLOCK_CAPACITY)
	) i_line_store (
		.clock_i (clock_i),
		.wr_i    (wr),
		.addr_i  (addr),
		.data_i  (wr_data),
		.data_o  (rd_data)
	);

endmodule

`default_nettype wire

// ==== fa_cache_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module fa_cache_asserts
	import cache_pkg::*;
(
	input wire logic       clock_i,
	input wire logic       resetn_i,
	input wire logic       enable_i,
	input wire logic       core_req_i,
	input wire logic       core_hit_o,
	input wire logic       core_done_o,
	input wire logic       buffer_read_ready_i,
	input wire logic       buffer_read_ack_o,
	input wire logic       buffer_write_ready_i,
	input wire logic       buffer_write_ack_o,
	input wire logic       mem_req_o,
	input wire logic       mem_rw_o,
	input wire word_addr_u mem_addr_o
);

	int unsigned fail_count = 0;    // read by the testbench at the end

	// memory side
	// --------------------
	mem_req_pulse: assert property (@(posedge clock_i) disable iff (!resetn_i)
		mem_req_o |=> !mem_req_o)
	else begin
		fail_count++;
		$error("mem_req_o held high for more than one cycle");
	end

	write_block_aligned: assert property (@(posedge clock_i) disable iff (!resetn_i)
		(mem_req_o && mem_rw_o) |-> (mem_addr_o.field.word == '0))
	else begin
		fail_count++;
		$error("write request address not block aligned");
	end

	// buffer pops and pushes only under ready
	read_ack_ready: assert property (@(posedge clock_i) disable iff (!resetn_i)
		buffer_read_ack_o |-> buffer_read_ready_i)
	else begin
		fail_count++;
		$error("read buffer ack without ready");
	end

	write_ack_ready: assert property (@(posedge clock_i) disable iff (!resetn_i)
		buffer_write_ack_o |-> buffer_write_ready_i)
	else begin
		fail_count++;
		$error("write buffer ack without ready");
	end

	// core side
	// --------------------
	hit_done_latency: assert property (@(posedge clock_i) disable iff (!resetn_i)
		(enable_i && core_req_i && !core_done_o && core_hit_o) |=> core_done_o)
	else begin
		fail_count++;
		$error("core_done_o did not follow a sampled hit by one cycle");
	end

endmodule

bind fa_cache_top fa_cache_asserts i_fa_cache_asserts (.*);

`default_nettype wire

// ==== tb_fa_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fa_cache
	import cache_pkg::*;
();

	localparam int              CAPACITY        = 8;
	localparam logic [31:0]     SEED            = 32'h48bb;
	localparam logic [31:0]     INIT_XOR        = 32'hA5A5_0000;   // untouched memory pattern
	localparam logic [BW_TAG-1:0] BASE_TAG      = 22'h2_a400;
	localparam int              RANDOM_ACCESSES = 120;
	localparam int              ACCESS_LIMIT    = 200;
	// ~135 accesses, worst miss with writeback ~40 cycles under back-pressure
	localparam int              TIMEOUT_CYCLES  = 6000;

	logic               clock;
	logic               resetn;
	logic               enable;
	logic               core_req;
	logic               core_rw;
	word_addr_u         core_addr;
	logic [BW_DATA-1:0] core_data;
	logic               core_done;
	logic               core_hit;
	logic [BW_DATA-1:0] core_rdata;
	logic               buffer_read_ready  = 1'b0;
	logic [BW_DATA-1:0] buffer_rdata       = '0;
	logic               buffer_read_ack;
	logic               buffer_write_ready = 1'b0;
	logic [BW_DATA-1:0] buffer_wdata;
	logic               buffer_write_ack;
	logic               mem_ready          = 1'b0;
	logic               mem_req;
	logic               mem_rw;
	word_addr_u         mem_addr;
	logic               flag_hit;
	logic               flag_miss;
	logic               flag_wb;

	logic [31:0] mem_model [logic [23:0]];    // memory behind the buffers
	logic [31:0] exp_mem   [logic [23:0]];    // what the core has written
	logic [31:0] rq [$];                      // read buffer contents
	logic [31:0] wq [$];                      // write buffer contents
	word_addr_u  waq [$];                     // write requests awaiting data
	int          n_hit = 0, n_miss = 0, n_wb = 0, n_rd_req = 0, n_wr_req = 0;
	word_addr_u  last_rd_addr, last_wr_addr;
	int          errors = 0;
	int          cycles = 0;
	logic [31:0] stim_state;
	logic [31:0] lvl_state = {SEED[15:0], SEED[31:16]};

	fa_cache_top #(
		.CACHE_BLOCK_CAPACITY (CAPACITY)
	) i_fa_cache_top (
		.clock_i (clock), .resetn_i (resetn), .enable_i (enable),
		.core_req_i (core_req), .core_rw_i (core_rw), .core_addr_i (core_addr),
		.core_data_i (core_data), .core_done_o (core_done), .core_hit_o (core_hit),
		.core_data_o (core_rdata),
		.buffer_read_ready_i (buffer_read_ready), .buffer_data_i (buffer_rdata),
		.buffer_read_ack_o (buffer_read_ack), .buffer_write_ready_i (buffer_write_ready),
		.buffer_data_o (buffer_wdata), .buffer_write_ack_o (buffer_write_ack),
		.mem_ready_i (mem_ready), .mem_req_o (mem_req), .mem_rw_o (mem_rw),
		.mem_addr_o (mem_addr), .flag_hit_o (flag_hit), .flag_miss_o (flag_miss),
		.flag_writeback_o (flag_wb)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] model_word(input logic [23:0] a);
		if (mem_model.exists(a))
			return mem_model[a];
		return {8'h00, a} ^ INIT_XOR;
	endfunction

	function automatic logic [31:0] expected_word(input logic [23:0] a);
		if (exp_mem.exists(a))
			return exp_mem[a];
		return {8'h00, a} ^ INIT_XOR;
	endfunction

	function automatic logic [23:0] blk_addr(input int tag_off, input int word);
		word_addr_u w;
		w.field.tag  = BASE_TAG + BW_TAG'(tag_off);
		w.field.word = BW_BLOCK'(word);
		return w.flat;
	endfunction

	task automatic check(input logic ok, input string msg);
		assert (ok) else begin
			errors++;
			$display("FAIL %0t: %s", $time, msg);
		end
	endtask

	// one core access, starts and ends on a falling edge
	task automatic access(input logic rw, input logic [23:0] a, input logic [31:0] d,
			output logic hit_first, output int latency);
		core_req       = 1'b1;
		core_rw        = rw;
		core_addr.flat = a;
		core_data      = d;
		@(posedge clock);
		hit_first = core_hit;                // lookup as sampled
		@(negedge clock);
		latency = 1;
		while (!core_done && latency < ACCESS_LIMIT) begin
			@(negedge clock);
			latency++;
		end
		if (!core_done) begin
			errors++;
			$display("access to address %h did not complete in %0d cycles", a, ACCESS_LIMIT);
		end else if (!rw) begin
			check(core_rdata == expected_word(a),
				$sformatf("read %h returned %h, expected %h", a, core_rdata, expected_word(a)));
		end else begin
			exp_mem[a] = d;
		end
		core_req = 1'b0;
		@(negedge clock);                    // let the flag counters catch up
	endtask

	// clock and run limit
	// --------------------
	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Some tests failed");
			$finish;
		end
	end

	// memory and buffer model
	// --------------------
	always @(posedge clock) begin
		word_addr_u wa;
		if (resetn) begin
			if (buffer_write_ack) wq.push_back(buffer_wdata);
			if (buffer_read_ack) void'(rq.pop_front());
			if (flag_hit) n_hit++;
			if (flag_miss) n_miss++;
			if (flag_wb) n_wb++;
			if (mem_req && mem_rw) begin
				n_wr_req++;
				last_wr_addr = mem_addr;
				waq.push_back(mem_addr);
			end
			// block lands once all four words are in
			while (waq.size() > 0 && wq.size() >= 4) begin
				wa = waq.pop_front();
				for (int i = 0; i < 4; i++)
					mem_model[24'(wa.flat + i)] = wq.pop_front();
			end
			if (mem_req && !mem_rw) begin
				n_rd_req++;
				last_rd_addr = mem_addr;
				for (int i = 0; i < 4; i++)
					rq.push_back(model_word(24'(mem_addr.flat + i)));
			end
		end
	end

	// random ready levels, memory never busy two cycles in a row
	always @(negedge clock) begin
		lvl_state = xorshift(lvl_state);
		buffer_write_ready <= lvl_state[0];
		buffer_read_ready  <= lvl_state[1] && (rq.size() > 0);
		buffer_rdata       <= (rq.size() > 0) ? rq[0] : '0;
		mem_ready          <= mem_ready ? (lvl_state[3:2] != 2'b00) : 1'b1;
	end

	// stimulus
	// --------------------
	initial begin
		logic [23:0] a_addr;
		logic [23:0] a;
		logic [31:0] wdata;
		logic        hit;
		logic        rw;
		int          lat;
		int          rd0, wr0, m0, h0, wb0;
		resetn     = 1'b0;
		enable     = 1'b1;
		core_req   = 1'b0;
		core_rw    = 1'b0;
		core_addr  = '0;
		core_data  = '0;
		stim_state = SEED;
		a_addr     = blk_addr(0, 1);
		wdata      = 32'h5eed_c0de;
		repeat (8) @(negedge clock);
		check(!core_done && !mem_req && !buffer_read_ack && !buffer_write_ack &&
			!flag_hit && !flag_miss && !flag_wb, "outputs not idle during reset");
		resetn = 1'b1;
		@(negedge clock);

		// cold read miss
		rd0 = n_rd_req;
		m0  = n_miss;
		access(1'b0, a_addr, '0, hit, lat);
		check(!hit, "first access after reset did not miss");
		check(n_rd_req == rd0 + 1, "cold miss did not issue one read request");
		check(last_rd_addr.flat == {a_addr[23:2], 2'b00}, "read request not block aligned");
		check(n_miss == m0 + 1, "miss flag did not pulse once");

		// write hit, makes line 0 dirty
		h0  = n_hit;
		rd0 = n_rd_req;
		wr0 = n_wr_req;
		access(1'b1, a_addr, wdata, hit, lat);
		check(hit && lat == 1, $sformatf("write hit: hit %0b latency %0d", hit, lat));
		check(n_hit == h0 + 1, "hit flag did not pulse on write hit");
		check(n_rd_req == rd0 && n_wr_req == wr0, "memory request on a hit");

		// fill lines 1..7, then the 8th miss evicts line 0
		wb0 = n_wb;
		for (int i = 1; i <= CAPACITY; i++)
			access(1'b0, blk_addr(i, i % 4), '0, hit, lat);
		check(n_wb == wb0 + 1, "dirty eviction gave no writeback flag");
		check(n_wr_req == wr0 + 1, "dirty eviction gave no single write request");
		check(last_wr_addr.flat == {a_addr[23:2], 2'b00}, "writeback to wrong block");
		check(model_word(a_addr) == wdata, "memory did not receive the written word");

		// re-read evicts the clean line 1
		access(1'b0, a_addr, '0, hit, lat);
		check(!hit, "evicted block still hit");
		check(n_wb == wb0 + 1 && n_wr_req == wr0 + 1, "clean eviction wrote back");

		// read hit
		h0  = n_hit;
		rd0 = n_rd_req;
		access(1'b0, a_addr, '0, hit, lat);
		check(hit && lat == 1, $sformatf("read hit: hit %0b latency %0d", hit, lat));
		check(n_hit == h0 + 1 && n_rd_req == rd0, "read hit flag or request wrong");

		// random mix over 16 blocks
		for (int i = 0; i < RANDOM_ACCESSES; i++) begin
			stim_state = xorshift(stim_state);
			a          = blk_addr(int'(stim_state[3:0]), int'(stim_state[5:4]));
			rw         = stim_state[8];
			stim_state = xorshift(stim_state);
			access(rw, a, stim_state, hit, lat);
		end

		$display("errors: %0d testbench checks, %0d assertion failures", errors,
			i_fa_cache_top.i_fa_cache_asserts.fail_count);
		if (errors == 0 && i_fa_cache_top.i_fa_cache_asserts.fail_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
cache_pkg.sv
fill_counters.sv
tag_cam.sv
line_store.sv
cache_fsm.sv
fa_cache_top.sv
fa_cache_asserts.sv
tb_fa_cache.sv
